/* run_sim.sh */
#!/bin/sh
# Build and run the wide timer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f wide_timer_mmio.f \
	--top-module wide_timer_mmio_tb -o sim_wide_timer
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/sim_wide_timer)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "Test passed"; then
	exit 0
fi
exit 1

/* source/mmio_addr_decode.sv */
// *************************************************************************
// MMIO address decode
// Turns one strobe-based bus request into exclusive register selects
// *************************************************************************

`timescale 1ns/1ps

`include "wide_timer_settings.svh"

module mmio_addr_decode import wide_timer_pkg::*; (
	input mmio_req_t req,
	output reg_sel_t sel
);

	// Address hits, not yet gated by a strobe
	logic hit_ctrl;
	logic hit_step;
	logic hit_capture;
	logic hit_wide;
	logic hit_id;

	assign hit_ctrl = (req.addr == `ADDR_CTRL);
	assign hit_step = (req.addr == `ADDR_STEP);
	assign hit_capture = (req.addr == `ADDR_CAPTURE);
	assign hit_wide = (req.addr == `ADDR_WIDE);
	assign hit_id = (req.addr == `ADDR_ID);

	always_comb begin
		// Write side
		// writes to read-only or unknown addresses just drop
		sel.ctrl_we = req.we && hit_ctrl;
		sel.step_we = req.we && hit_step;
		sel.capture_we = req.we && hit_capture;

		// Read side
		sel.ctrl_re = req.re && hit_ctrl;
		sel.step_re = req.re && hit_step;
		sel.wide_re = req.re && hit_wide;
		sel.id_re = req.re && hit_id;

		// Capture is write only, so reading it counts as unmapped
		sel.unmapped_re = req.re && !(hit_ctrl || hit_step || hit_wide || hit_id);

		// Payload passes straight through
		sel.wdata = req.wdata;
	end

	// *********************************************************************
	// Checks
	// *********************************************************************

	// Bus master must never read and write in one cycle
	always_comb begin
		assert final (!(req.re && req.we))
			else $error("mmio_addr_decode: re and we high together");
	end

	// Selects stay exclusive across read and write sides
	always_comb begin
		assert final ($onehot0({sel.ctrl_we, sel.step_we, sel.capture_we,
			sel.ctrl_re, sel.step_re, sel.wide_re, sel.id_re, sel.unmapped_re}))
			else $error("mmio_addr_decode: more than one select high");
	end

endmodule

/* source/mmio_read_return.sv */
// *************************************************************************
// MMIO read return
// Picks the readback source and registers it with a one-cycle
// valid pulse
// *************************************************************************

`timescale 1ns/1ps

`include "wide_timer_settings.svh"

module mmio_read_return import wide_timer_pkg::*; (
	input logic clk,
	input logic rst,
	input reg_sel_t sel,
	input timer_ctrl_t ctrl,
	input wide_value_t snapshot,
	output mmio_word_t rdata,
	output logic rdata_valid
);

	mmio_word_t slice_word;
	mmio_word_t read_word;
	logic any_re;

	// Capture restarts the word sequence, each wide read moves it on
	wide_read_slicer i_slicer (
		.clk(clk),
		.rst(rst),
		.restart(sel.capture_we),
		.advance(sel.wide_re),
		.snapshot(snapshot),
		.word(slice_word)
	);

	// Source select; unmapped reads fall through to zero
	always_comb begin
		read_word = '0;
		if (sel.ctrl_re) begin
			read_word = mmio_word_t'(ctrl.enable);
		end else if (sel.step_re) begin
			read_word = ctrl.step;
		end else if (sel.wide_re) begin
			read_word = slice_word;
		end else if (sel.id_re) begin
			read_word = `TIMER_ID;
		end
	end

	assign any_re = sel.ctrl_re || sel.step_re || sel.wide_re || sel.id_re || sel.unmapped_re;

	// One cycle latency, data holds until the next read
	always_ff @(posedge clk) begin
		if (rst) begin
			rdata <= '0;
			rdata_valid <= 1'b0;
		end else begin
			rdata_valid <= any_re;
			if (any_re) begin
				rdata <= read_word;
			end
		end
	end

endmodule

/* source/wide_read_slicer.sv */
// *************************************************************************
// Wide read slicer
// Circular one-hot word pointer plus one-hot mux, hands out the
// snapshot one bus word per read, low word first
// *************************************************************************

`timescale 1ns/1ps

`include "wide_timer_settings.svh"

module wide_read_slicer import wide_timer_pkg::*; (
	input logic clk,
	input logic rst,
	input logic restart,
	input logic advance,
	input wide_value_t snapshot,
	output mmio_word_t word
);

	// Word pointer, bit i selects bus word i
	word_onehot_t ptr;

	// *********************************************************************
	// Pointer
	// *********************************************************************

	always_ff @(posedge clk) begin
		if (rst || restart) begin
			// Back to the low word
			ptr <= word_onehot_t'(1);
		end else if (advance) begin
			// Rotate left, top word wraps to word 0
			ptr <= {ptr[`NUM_WORDS-2:0], ptr[`NUM_WORDS-1]};
		end
	end

	// *********************************************************************
	// One-hot mux
	// *********************************************************************

	always_comb begin
		word = '0;
		// OR of the gated slices; exactly one term is live
		for (int i = 0; i < `NUM_WORDS; i++) begin
			if (ptr[i]) begin
				word = word | snapshot[i*`BW_MMIO +: `BW_MMIO];
			end
		end
	end

	// Pointer never loses or duplicates its token
	a_ptr_onehot: assert property (
		@(posedge clk) disable iff (rst)
		$onehot(ptr)
	) else $error("wide_read_slicer: pointer not one-hot");

endmodule

/* source/wide_timer_core.sv */
// *************************************************************************
// Wide timer core
// Enable and step registers, 96-bit free-running counter and the
// snapshot register loaded on a capture write
// *************************************************************************

`timescale 1ns/1ps

`include "wide_timer_settings.svh"

module wide_timer_core import wide_timer_pkg::*; (
	input logic clk,
	input logic rst,
	input reg_sel_t sel,
	output timer_ctrl_t ctrl,
	output wide_value_t snapshot
);

	// Control registers
	logic enable;
	mmio_word_t step;

	// Running count, wraps modulo 2**96
	wide_value_t counter;

	// *********************************************************************
	// Control registers
	// *********************************************************************

	always_ff @(posedge clk) begin
		if (rst) begin
			enable <= 1'b0;
			step <= `RESET_STEP;
		end else begin
			// Only bit 0 of the control word is defined
			if (sel.ctrl_we) begin
				enable <= sel.wdata[0];
			end
			if (sel.step_we) begin
				step <= sel.wdata;
			end
		end
	end

	// *********************************************************************
	// Counter and snapshot
	// *********************************************************************

	always_ff @(posedge clk) begin
		if (rst) begin
			counter <= '0;
			snapshot <= '0;
		end else begin
			// Step is zero-extended to the counter width
			if (enable) begin
				counter <= counter + wide_value_t'(step);
			end
			// Snapshot takes the count held before this edge
			if (sel.capture_we) begin
				snapshot <= counter;
			end
		end
	end

	// Readback view
	assign ctrl.enable = enable;
	assign ctrl.step = step;

	// Counter frozen for as long as the timer is disabled
	a_hold_when_disabled: assert property (
		@(posedge clk) disable iff (rst)
		!enable |=> (counter == $past(counter))
	) else $error("wide_timer_core: counter moved while disabled");

endmodule

/* source/wide_timer_mmio.sv */
// *************************************************************************
// Wide timer MMIO top
// 96-bit stepped timer with capture, read as three bus words
// *************************************************************************

`timescale 1ns/1ps

module wide_timer_mmio import wide_timer_pkg::*; (
	input logic clk,
	input logic rst,
	input logic re,
	input logic we,
	input mmio_addr_t addr,
	input mmio_word_t wdata,
	output mmio_word_t rdata,
	output logic rdata_valid
);

	mmio_req_t req;
	reg_sel_t sel;
	timer_ctrl_t ctrl;
	wide_value_t snapshot;

	// Bundle the pins into one request
	assign req = {re, we, addr, wdata};

	// Decode stage
	mmio_addr_decode i_decode (
		.req(req),
		.sel(sel)
	);

	// Execute stage
	wide_timer_core i_core (
		.clk(clk),
		.rst(rst),
		.sel(sel),
		.ctrl(ctrl),
		.snapshot(snapshot)
	);

	// Result stage
	mmio_read_return i_return (
		.clk(clk),
		.rst(rst),
		.sel(sel),
		.ctrl(ctrl),
		.snapshot(snapshot),
		.rdata(rdata),
		.rdata_valid(rdata_valid)
	);

endmodule

/* source/wide_timer_pkg.sv */
// *************************************************************************
// Wide timer package
// Bus vector types and the structs passed between decode, execute
// and result stages
// *************************************************************************

`include "wide_timer_settings.svh"

package wide_timer_pkg;

	// Plain vectors with a meaning
	typedef logic [`BW_MMIO-1:0] mmio_word_t;
	typedef logic [`BW_ADDR-1:0] mmio_addr_t;
	typedef logic [`BW_WIDE-1:0] wide_value_t;
	typedef logic [`NUM_WORDS-1:0] word_onehot_t;

	// One bus request as seen at the pins
	typedef struct packed {
		logic re;
		logic we;
		mmio_addr_t addr;
		mmio_word_t wdata;
	} mmio_req_t;

	// Decoded selects, at most one high per cycle
	typedef struct packed {
		logic ctrl_we;
		logic step_we;
		logic capture_we;
		logic ctrl_re;
		logic step_re;
		logic wide_re;
		logic id_re;
		logic unmapped_re;
		mmio_word_t wdata;
	} reg_sel_t;

	// Control state read back from the execute stage
	typedef struct packed {
		logic enable;
		mmio_word_t step;
	} timer_ctrl_t;

endpackage

/* source/wide_timer_settings.svh */
// *************************************************************************
// Wide timer settings
// Bus and counter widths, register map and reset values
// *************************************************************************

`ifndef WIDE_TIMER_SETTINGS_SVH
`define WIDE_TIMER_SETTINGS_SVH

// Bus word and counter widths
`define BW_MMIO 32
`define BW_WIDE 96

// Bus words per snapshot, low word first
`define NUM_WORDS 3

// Word address width
`define BW_ADDR 3

// Register map, word addresses
`define ADDR_CTRL 3'd0
`define ADDR_STEP 3'd1
`define ADDR_CAPTURE 3'd2
`define ADDR_WIDE 3'd3
`define ADDR_ID 3'd4

// Identity word, ASCII "WTIM"
`define TIMER_ID 32'h5754_494D

// Counter increment after reset
`define RESET_STEP 32'd1

`endif

/* tb/wide_timer_mmio_tb.sv */
// *************************************************************************
// Wide timer MMIO testbench
// LFSR-driven bus traffic against a reference model, checked by
// concurrent assertions one cycle after each read strobe
// *************************************************************************

`timescale 1ns/1ps

`include "wide_timer_settings.svh"

module wide_timer_mmio_tb import wide_timer_pkg::*; ();

	logic clk;
	logic rst;
	logic re;
	logic we;
	mmio_addr_t addr;
	mmio_word_t wdata;
	mmio_word_t rdata;
	logic rdata_valid;

	// Reference model of the register map
	logic m_en;
	mmio_word_t m_step;
	wide_value_t m_cnt;
	wide_value_t m_snap;
	int m_ptr;
	mmio_word_t exp_word;
	mmio_word_t exp_q;
	logic chk_q;

	logic [31:0] lfsr;
	int cyc;
	int wr_cyc;

	wide_timer_mmio i_dut (
		.clk(clk),
		.rst(rst),
		.re(re),
		.we(we),
		.addr(addr),
		.wdata(wdata),
		.rdata(rdata),
		.rdata_valid(rdata_valid)
	);

	// 20 ns clock
	always #10 clk = ~clk;

	// *********************************************************************
	// Reference model
	// *********************************************************************

	always @(posedge clk) begin
		if (rst) begin
			m_en <= 1'b0;
			m_step <= `RESET_STEP;
			m_cnt <= '0;
			m_snap <= '0;
			m_ptr <= 0;
			chk_q <= 1'b0;
			exp_q <= '0;
			cyc <= 0;
		end else begin
			// Counter steps on every edge while enabled
			if (m_en) begin
				m_cnt <= m_cnt + wide_value_t'(m_step);
			end
			if (we && addr == `ADDR_CTRL) begin
				m_en <= wdata[0];
			end
			if (we && addr == `ADDR_STEP) begin
				m_step <= wdata;
			end
			// Capture takes the old count and restarts at the low word
			if (we && addr == `ADDR_CAPTURE) begin
				m_snap <= m_cnt;
				m_ptr <= 0;
			end else if (re && addr == `ADDR_WIDE) begin
				m_ptr <= (m_ptr == `NUM_WORDS - 1) ? 0 : m_ptr + 1;
			end
			// Expectation for the word returned after this edge
			chk_q <= re;
			exp_q <= exp_word;
			cyc <= cyc + 1;
		end
	end

	always_comb begin
		case (addr)
			`ADDR_CTRL: exp_word = mmio_word_t'(m_en);
			`ADDR_STEP: exp_word = m_step;
			`ADDR_WIDE: exp_word = m_snap[m_ptr*`BW_MMIO +: `BW_MMIO];
			`ADDR_ID: exp_word = `TIMER_ID;
			// Capture address and holes read as zero
			default: exp_word = '0;
		endcase
	end

	// *********************************************************************
	// Checks
	// *********************************************************************

	task automatic fail_run();
		$display("Test failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] want);
		$display("error: %s 0x%h expected 0x%h", name, got, want);
		fail_run();
	endtask

	task automatic report_timeout(string what);
		$display("timed out waiting for %s", what);
		fail_run();
	endtask

	// Valid pulse exactly one cycle after each read strobe, never otherwise
	a_valid: assert property (@(posedge clk) disable iff (rst) rdata_valid == chk_q)
		else report_mismatch("rdata_valid", 32'($sampled(rdata_valid)),
			32'($sampled(chk_q)));

	// Returned word matches the model
	a_rdata: assert property (@(posedge clk) disable iff (rst) chk_q |-> rdata == exp_q)
		else report_mismatch("rdata", $sampled(rdata), $sampled(exp_q));

	// *********************************************************************
	// Stimulus helpers
	// *********************************************************************

	// Galois LFSR, one step per bit taken
	function automatic logic [31:0] take_bits(int n);
		logic [31:0] bits;
		logic lsb;
		bits = '0;
		for (int i = 0; i < n; i++) begin
			lsb = lfsr[0];
			lfsr = lfsr >> 1;
			if (lsb) begin
				lfsr = lfsr ^ 32'h8020_0003;
			end
			bits = {bits[30:0], lsb};
		end
		return bits;
	endfunction

	task automatic write_reg(mmio_addr_t a, mmio_word_t d);
		@(posedge clk);
		we <= 1'b1;
		addr <= a;
		wdata <= d;
		wr_cyc = cyc;
		@(posedge clk);
		we <= 1'b0;
	endtask

	task automatic read_reg(mmio_addr_t a, output mmio_word_t d);
		int tries;
		@(posedge clk);
		re <= 1'b1;
		addr <= a;
		@(posedge clk);
		re <= 1'b0;
		tries = 0;
		@(negedge clk);
		while (!rdata_valid && tries < 8) begin
			@(negedge clk);
			tries++;
		end
		if (!rdata_valid) begin
			report_timeout("read data valid");
		end
		d = rdata;
	endtask

	// Three wide reads, low word first
	task automatic read_wide(output wide_value_t v);
		mmio_word_t w;
		for (int i = 0; i < `NUM_WORDS; i++) begin
			read_reg(`ADDR_WIDE, w);
			v[i*`BW_MMIO +: `BW_MMIO] = w;
		end
	endtask

	// *********************************************************************
	// Test sequence
	// *********************************************************************

	initial begin
		wide_value_t snap_a;
		wide_value_t snap_b;
		mmio_word_t w;
		mmio_word_t step;
		int t_a;
		clk = 1'b0;
		rst = 1'b1;
		re = 1'b0;
		we = 1'b0;
		addr = '0;
		wdata = '0;
		lfsr = 32'h6625;
		wr_cyc = 0;
		repeat (5) @(posedge clk);
		rst <= 1'b0;

		// Idle, then a capture while disabled reads back as zero
		repeat (4) @(posedge clk);
		write_reg(`ADDR_CAPTURE, take_bits(32));
		read_wide(snap_a);

		// Control, step, identity and unmapped reads
		write_reg(`ADDR_CTRL, 32'h0);
		step = take_bits(32);
		write_reg(`ADDR_STEP, step);
		read_reg(`ADDR_CTRL, w);
		read_reg(`ADDR_STEP, w);
		read_reg(`ADDR_ID, w);
		read_reg(3'd5, w);
		read_reg(`ADDR_CAPTURE, w);

		// Running counter, two captures some cycles apart
		write_reg(`ADDR_CTRL, 32'h1);
		// Enable reads back as set
		read_reg(`ADDR_CTRL, w);
		repeat (take_bits(4) + 2) @(posedge clk);
		write_reg(`ADDR_CAPTURE, 32'h0);
		t_a = wr_cyc;
		read_wide(snap_a);
		repeat (take_bits(3)) @(posedge clk);
		write_reg(`ADDR_CAPTURE, 32'h0);
		read_wide(snap_b);
		if (snap_b - snap_a != wide_value_t'(wr_cyc - t_a) * wide_value_t'(step)) begin
			$display("error: snapshot delta 0x%h expected 0x%h", snap_b - snap_a,
				wide_value_t'(wr_cyc - t_a) * wide_value_t'(step));
			fail_run();
		end

		// Fourth read wraps to the low word, capture restarts mid sequence
		read_reg(`ADDR_WIDE, w);
		read_reg(`ADDR_WIDE, w);
		write_reg(`ADDR_CAPTURE, 32'h0);
		read_reg(`ADDR_WIDE, w);

		// Disabled counter gives equal snapshots
		write_reg(`ADDR_CTRL, 32'h0);
		write_reg(`ADDR_CAPTURE, 32'h0);
		read_wide(snap_a);
		repeat (take_bits(4) + 1) @(posedge clk);
		write_reg(`ADDR_CAPTURE, 32'h0);
		read_wide(snap_b);
		if (snap_a != snap_b) begin
			$display("error: snapshot 0x%h expected 0x%h", snap_b, snap_a);
			fail_run();
		end

		// Back-to-back wide reads
		write_reg(`ADDR_CAPTURE, 32'h0);
		@(posedge clk);
		re <= 1'b1;
		addr <= `ADDR_WIDE;
		repeat (`NUM_WORDS) @(posedge clk);
		re <= 1'b0;
		repeat (3) @(posedge clk);

		$display("Test passed");
		$finish;
	end

endmodule

/* wide_timer_mmio.f */
+incdir+source
source/wide_timer_pkg.sv
source/mmio_addr_decode.sv
source/wide_timer_core.sv
source/wide_read_slicer.sv
source/mmio_read_return.sv
source/wide_timer_mmio.sv
tb/wide_timer_mmio_tb.sv
